// File: rtl/sample_feed_pkg.sv
`default_nettype none

package sample_feed_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data path widths and depths
   ////////////////////////////////////////////////////////////////////////////

   localparam int word_width   = 16;
   localparam int sample_width = 3;

   // One word plus the two residue bits a word can leave behind
   localparam int buffer_width = word_width + 2;

   localparam int fifo_depth   = 16;

   // Refill once fewer than two whole samples are held
   localparam int refill_bits  = 2 * sample_width;

   ////////////////////////////////////////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [word_width-1:0]   word_t;
   typedef logic [sample_width-1:0] sample_t;
   typedef logic [buffer_width-1:0] buffer_t;

   // Fill level runs 0..fifo_depth, one bit wider than a pointer
   typedef logic [$clog2(fifo_depth+1)-1:0]   level_t;

   // Bits held in the sample buffer, 0..buffer_width
   typedef logic [$clog2(buffer_width+1)-1:0] bits_t;

   // Feed controller states
   typedef enum logic [1:0] {
      feed_idle,
      feed_fill,
      feed_stream,
      feed_starve
   } feed_state_t;

endpackage

`default_nettype wire

// File: rtl/word_fifo.sv
`default_nettype none

module word_fifo (
   input  logic                    clk_sample,
   input  logic                    rst,
   input  logic                    wr,
   input  sample_feed_pkg::word_t  wr_data,
   input  logic                    rd,
   output sample_feed_pkg::word_t  head,
   output logic                    empty,
   output logic                    full,
   output sample_feed_pkg::level_t level
);

   // Storage, no reset needed on the data itself
   sample_feed_pkg::word_t mem [sample_feed_pkg::fifo_depth];

   // Depth is a power of two so the pointers wrap on their own
   logic [$clog2(sample_feed_pkg::fifo_depth)-1:0] wr_ptr;
   logic [$clog2(sample_feed_pkg::fifo_depth)-1:0] rd_ptr;

   logic wr_ok;
   logic rd_ok;

   // A write into a full FIFO is dropped
   assign wr_ok = wr && !full;
   assign rd_ok = rd && !empty;

   always_ff @(posedge clk_sample) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk_sample) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Level moves only when exactly one side is active
         case ({wr_ok, rd_ok})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // First word fall through, head is valid whenever empty is low
   assign head  = mem[rd_ptr];
   assign empty = (level == '0);
   assign full  = (level == sample_feed_pkg::level_t'(sample_feed_pkg::fifo_depth));

   // The source must watch the full level
   a_no_write_when_full: assert property (
      @(posedge clk_sample) disable iff (rst)
      wr |-> !full
   ) else $error("word_fifo: write while full");

   // The feed controller must only pop a word it can see
   a_no_read_when_empty: assert property (
      @(posedge clk_sample) disable iff (rst)
      rd |-> !empty
   ) else $error("word_fifo: read while empty");

endmodule

`default_nettype wire

// File: rtl/bit_residue_counter.sv
`default_nettype none

module bit_residue_counter (
   input  logic                   clk_sample,
   input  logic                   rst,
   input  logic                   take,
   input  logic                   shift,
   output sample_feed_pkg::bits_t bits_held,
   output logic                   refill_due,
   output logic                   sample_ready
);

   sample_feed_pkg::bits_t bits_next;

   // A take adds a whole word, a shift removes one sample,
   // both may happen in the same cycle
   always_comb begin
      bits_next = bits_held;
      if (take) begin
         bits_next = bits_next + sample_feed_pkg::bits_t'(sample_feed_pkg::word_width);
      end
      if (shift) begin
         bits_next = bits_next - sample_feed_pkg::bits_t'(sample_feed_pkg::sample_width);
      end
   end

   always_ff @(posedge clk_sample) begin
      if (rst) begin
         bits_held <= '0;
      end else begin
         bits_held <= bits_next;
      end
   end

   // Fewer than two whole samples left
   assign refill_due   = bits_held < sample_feed_pkg::bits_t'(sample_feed_pkg::refill_bits);
   assign sample_ready = bits_held >= sample_feed_pkg::bits_t'(sample_feed_pkg::sample_width);

   // The controller only loads when the word still fits in the buffer
   a_no_overflow: assert property (
      @(posedge clk_sample) disable iff (rst)
      bits_held <= sample_feed_pkg::buffer_width
   ) else $error("bit_residue_counter: buffer overflow, %0d bits", bits_held);

   // A shift never takes more bits than are held
   a_no_underflow: assert property (
      @(posedge clk_sample) disable iff (rst)
      shift |-> bits_held >= sample_feed_pkg::sample_width
   ) else $error("bit_residue_counter: shift with only %0d bits", bits_held);

endmodule

`default_nettype wire

// File: rtl/feed_control.sv
`default_nettype none

module feed_control (
   input  logic clk_sample,
   input  logic rst,
   input  logic fifo_empty,
   input  logic refill_due,
   input  logic sample_ready,
   output logic word_take,
   output logic bit_shift,
   output logic starve
);

   sample_feed_pkg::feed_state_t state;
   sample_feed_pkg::feed_state_t state_next;

   ////////////////////////////////////////////////////////////////////////////
   // Strobes
   ////////////////////////////////////////////////////////////////////////////

   // Pop and buffer load share one strobe. Idle waits one cycle in
   // feed_fill before the first load, which fixes the start-up latency
   assign word_take = (state != sample_feed_pkg::feed_idle) &&
                      !fifo_empty && refill_due;

   // Samples go out only while streaming, refill may overlap
   assign bit_shift = (state == sample_feed_pkg::feed_stream) && sample_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Feed state machine
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         sample_feed_pkg::feed_idle: begin
            if (!fifo_empty) begin
               state_next = sample_feed_pkg::feed_fill;
            end
         end

         sample_feed_pkg::feed_fill: begin
            // First word lands in the empty buffer
            if (word_take) begin
               state_next = sample_feed_pkg::feed_stream;
            end
         end

         sample_feed_pkg::feed_stream: begin
            // Out of whole samples and nothing to refill with
            if (!sample_ready && fifo_empty) begin
               state_next = sample_feed_pkg::feed_starve;
            end
         end

         sample_feed_pkg::feed_starve: begin
            // Residue bits are kept, the next word joins them
            if (word_take) begin
               state_next = sample_feed_pkg::feed_stream;
            end
         end

         default: begin
            state_next = sample_feed_pkg::feed_idle;
         end
      endcase
   end

   always_ff @(posedge clk_sample) begin
      if (rst) begin
         state <= sample_feed_pkg::feed_idle;
      end else begin
         state <= state_next;
      end
   end

   // One pulse on each entry into starvation
   always_ff @(posedge clk_sample) begin
      if (rst) begin
         starve <= 1'b0;
      end else begin
         starve <= (state == sample_feed_pkg::feed_stream) &&
                   (state_next == sample_feed_pkg::feed_starve);
      end
   end

   // The residue stays below one sample until the next word is loaded
   a_starve_short: assert property (
      @(posedge clk_sample) disable iff (rst)
      (state == sample_feed_pkg::feed_starve) |-> !sample_ready
   ) else $error("feed_control: starving with a whole sample held");

endmodule

`default_nettype wire

// File: rtl/sample_unpacker.sv
`default_nettype none

module sample_unpacker (
   input  logic                     clk_sample,
   input  logic                     rst,
   input  logic                     take,
   input  logic                     shift,
   input  sample_feed_pkg::word_t   word,
   input  sample_feed_pkg::bits_t   bits_held,
   output logic                     sample_valid,
   output sample_feed_pkg::sample_t sample_out
);

   sample_feed_pkg::buffer_t buffer;
   sample_feed_pkg::buffer_t shifted;
   sample_feed_pkg::buffer_t keep_mask;
   sample_feed_pkg::buffer_t kept;
   sample_feed_pkg::buffer_t placed;

   // Residue bits left once this cycle's sample is gone
   sample_feed_pkg::bits_t   base;

   ////////////////////////////////////////////////////////////////////////////
   // Buffer update
   ////////////////////////////////////////////////////////////////////////////

   assign base = shift ? bits_held - sample_feed_pkg::bits_t'(sample_feed_pkg::sample_width)
                       : bits_held;

   assign shifted = shift ? (buffer >> sample_feed_pkg::sample_width) : buffer;

   // Only the live residue survives, stale upper bits are cleared
   assign keep_mask = ~({sample_feed_pkg::buffer_width{1'b1}} << base);
   assign kept      = shifted & keep_mask;

   // New word sits right above the residue, LSB first order kept
   assign placed = sample_feed_pkg::buffer_t'(word) << base;

   always_ff @(posedge clk_sample) begin
      if (take) begin
         buffer <= kept | placed;
      end else if (shift) begin
         buffer <= kept;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Sample output
   ////////////////////////////////////////////////////////////////////////////

   // Lowest three bits are the oldest sample
   always_ff @(posedge clk_sample) begin
      if (shift) begin
         sample_out <= buffer[sample_feed_pkg::sample_width-1:0];
      end
   end

   always_ff @(posedge clk_sample) begin
      if (rst) begin
         sample_valid <= 1'b0;
      end else begin
         sample_valid <= shift;
      end
   end

   // The controller's refill threshold keeps every loaded word inside the buffer
   a_word_fits: assert property (
      @(posedge clk_sample) disable iff (rst)
      take |-> (base + sample_feed_pkg::word_width) <= sample_feed_pkg::buffer_width
   ) else $error("sample_unpacker: word placed at bit %0d overflows", base);

endmodule

`default_nettype wire

// File: rtl/sample_feed.sv
`default_nettype none

module sample_feed (
   input  logic                     clk_sample,
   input  logic                     rst,
   input  logic                     word_wr,
   input  sample_feed_pkg::word_t   word_in,
   output logic                     fifo_full,
   output sample_feed_pkg::level_t  fifo_level,
   output logic                     sample_valid,
   output sample_feed_pkg::sample_t sample_out,
   output logic                     starve
);

   // FIFO head and state
   sample_feed_pkg::word_t fifo_head;
   logic                   fifo_empty;

   // Controller strobes
   logic                   word_take;
   logic                   bit_shift;

   // Buffer occupancy
   sample_feed_pkg::bits_t bits_held;
   logic                   refill_due;
   logic                   sample_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Word FIFO
   ////////////////////////////////////////////////////////////////////////////

   word_fifo fifo_i (
      .clk_sample (clk_sample),
      .rst        (rst),
      .wr         (word_wr),
      .wr_data    (word_in),
      .rd         (word_take),
      .head       (fifo_head),
      .empty      (fifo_empty),
      .full       (fifo_full),
      .level      (fifo_level)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Feed control and bit accounting
   ////////////////////////////////////////////////////////////////////////////

   bit_residue_counter counter_i (
      .clk_sample   (clk_sample),
      .rst          (rst),
      .take         (word_take),
      .shift        (bit_shift),
      .bits_held    (bits_held),
      .refill_due   (refill_due),
      .sample_ready (sample_ready)
   );

   feed_control control_i (
      .clk_sample   (clk_sample),
      .rst          (rst),
      .fifo_empty   (fifo_empty),
      .refill_due   (refill_due),
      .sample_ready (sample_ready),
      .word_take    (word_take),
      .bit_shift    (bit_shift),
      .starve       (starve)
   );

   // Sample buffer
   sample_unpacker unpacker_i (
      .clk_sample   (clk_sample),
      .rst          (rst),
      .take         (word_take),
      .shift        (bit_shift),
      .word         (fifo_head),
      .bits_held    (bits_held),
      .sample_valid (sample_valid),
      .sample_out   (sample_out)
   );

endmodule

`default_nettype wire

// File: test/sample_feed_tb.sv
`default_nettype none

module sample_feed_tb;

   localparam int half_period  = 4;
   localparam int reset_cycles = 8;
   localparam int stream_words = 64;
   localparam int resume_words = 6;
   localparam int full_words   = 32;
   localparam int wait_limit   = 200;

   // Burst, stream, resume, full and latency phases
   localparam int total_words  = 3 + stream_words + resume_words + full_words + 1;

   logic                     clk_sample;
   logic                     rst;
   logic                     word_wr;
   sample_feed_pkg::word_t   word_in;
   logic                     fifo_full;
   sample_feed_pkg::level_t  fifo_level;
   logic                     sample_valid;
   sample_feed_pkg::sample_t sample_out;
   logic                     starve;

   // Reference bit stream, oldest bit at the front
   bit   bit_queue[$];
   int   errors          = 0;
   int   samples_checked = 0;
   int   starve_pulses   = 0;
   int   words_accepted  = 0;
   int   words_popped    = 0;
   logic stream_check;
   logic latency_arm;
   logic latency_write;

   sample_feed sample_feed_i (
      .clk_sample   (clk_sample),
      .rst          (rst),
      .word_wr      (word_wr),
      .word_in      (word_in),
      .fifo_full    (fifo_full),
      .fifo_level   (fifo_level),
      .sample_valid (sample_valid),
      .sample_out   (sample_out),
      .starve       (starve)
   );

   assign latency_write = latency_arm && word_wr;

   initial begin
      clk_sample = 1'b0;
      forever #(half_period) clk_sample = ~clk_sample;
   end

   // Eight cycles per word plus slack for resets and drains
   initial begin
      #(total_words * 8 * 2 * half_period + 2000);
      $display("Timeout: run did not finish, %0d errors so far", errors);
      $display("sim failed");
      $finish;
   end

   task automatic report_mismatch(input string name, input int expected, input int actual);
      errors++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
   endtask

   task automatic log_failure(input string what);
      errors++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model, sampled on the falling edge
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk_sample) begin : model
      sample_feed_pkg::sample_t expected;
      int                       level_now;
      if (rst) begin
         bit_queue.delete();
         words_accepted = 0;
         words_popped   = 0;
      end else begin
         // Level covers every write and pop up to the last edge
         level_now = words_accepted - words_popped;
         assert (fifo_level == sample_feed_pkg::level_t'(level_now))
         else report_mismatch("fifo_level", level_now, int'(fifo_level));
         assert (fifo_full == (level_now == sample_feed_pkg::fifo_depth))
         else report_mismatch("fifo_full", int'(level_now == sample_feed_pkg::fifo_depth),
                              int'(fifo_full));
         if (sample_valid) begin
            if (bit_queue.size() < sample_feed_pkg::sample_width) begin
               log_failure("sample_valid with fewer than three bits written");
            end else begin
               for (int i = 0; i < sample_feed_pkg::sample_width; i++) begin
                  expected[i] = bit_queue.pop_front();
               end
               samples_checked++;
               assert (sample_out == expected)
               else report_mismatch("sample_out", int'(expected), int'(sample_out));
            end
         end
         if (starve) begin
            starve_pulses++;
         end
         if (sample_feed_i.word_take) begin
            words_popped++;
         end
         // Word bit 0 goes out first
         if (word_wr && level_now < sample_feed_pkg::fifo_depth) begin
            words_accepted++;
            for (int i = 0; i < sample_feed_pkg::word_width; i++) begin
               bit_queue.push_back(word_in[i]);
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Protocol and timing properties
   ////////////////////////////////////////////////////////////////////////////

   a_reset_state: assert property (@(posedge clk_sample)
      rst |=> !sample_valid && !starve && !fifo_full && fifo_level == '0)
      else log_failure("outputs not cleared by reset");

   a_starve_pulse: assert property (@(posedge clk_sample) disable iff (rst)
      starve |=> !starve)
      else log_failure("starve held longer than one cycle");

   a_starve_quiet: assert property (@(posedge clk_sample) disable iff (rst)
      starve |-> !sample_valid)
      else log_failure("sample_valid high during starve pulse");

   a_stream_unbroken: assert property (@(posedge clk_sample) disable iff (rst)
      stream_check |-> sample_valid && !starve)
      else log_failure("sample stream broke while words were supplied");

   // First sample exactly three cycles after the first write
   a_latency_quiet: assert property (@(posedge clk_sample) disable iff (rst)
      ($past(latency_write) || $past(latency_write, 2) || $past(latency_write, 3))
      |-> !sample_valid)
      else log_failure("first sample came too early");

   a_latency_first: assert property (@(posedge clk_sample) disable iff (rst)
      $past(latency_write, 4) |-> sample_valid)
      else log_failure("first sample missing three cycles after the write");

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge clk_sample);
      #1;
   endtask

   task automatic apply_reset();
      rst     = 1'b1;
      word_wr = 1'b0;
      repeat (reset_cycles) next_cycle();
      rst = 1'b0;
   endtask

   task automatic write_word(input sample_feed_pkg::word_t value);
      int waited;
      waited = 0;
      while (fifo_full && waited < wait_limit) begin
         next_cycle();
         waited++;
      end
      if (fifo_full) begin
         log_failure("fifo_full stayed high, word not written");
      end
      word_wr = !fifo_full;
      word_in = value;
      next_cycle();
      word_wr = 1'b0;
   endtask

   // Waits until every whole sample is out, then expects one starve pulse
   task automatic finish_phase(input int starve_before, input string phase);
      int waited;
      waited = 0;
      while (bit_queue.size() >= sample_feed_pkg::sample_width && waited < wait_limit) begin
         next_cycle();
         waited++;
      end
      repeat (4) next_cycle();
      if (bit_queue.size() >= sample_feed_pkg::sample_width) begin
         log_failure($sformatf("%s: %0d bits never came out", phase, bit_queue.size()));
      end
      if (starve_pulses - starve_before != 1) begin
         report_mismatch("starve", 1, starve_pulses - starve_before);
      end
   endtask

   initial begin : stimulus
      int starve_mark;
      int sample_mark;
      int written;
      void'($urandom(32'h16933474));
      rst          = 1'b1;
      word_wr      = 1'b0;
      word_in      = '0;
      stream_check = 1'b0;
      latency_arm  = 1'b0;
      apply_reset();

      if (sample_valid || starve || fifo_full) begin
         log_failure("outputs active after reset");
      end
      assert (fifo_level == '0) else report_mismatch("fifo_level", 0, int'(fifo_level));

      // Three known words, 48 bits give exactly 16 samples
      starve_mark = starve_pulses;
      sample_mark = samples_checked;
      write_word(16'hffff);
      write_word(16'haaaa);
      write_word(16'h3210);
      finish_phase(starve_mark, "burst");
      if (samples_checked - sample_mark != 16) begin
         report_mismatch("sample_valid count", 16, samples_checked - sample_mark);
      end

      // Random words as fast as the FIFO takes them
      starve_mark = starve_pulses;
      for (written = 0; written < stream_words; written++) begin
         if (sample_valid) begin
            stream_check = 1'b1;
         end
         write_word(sample_feed_pkg::word_t'($urandom));
      end
      stream_check = 1'b0;
      finish_phase(starve_mark, "stream stop");

      // Residue bits from the starved buffer lead the new words
      starve_mark = starve_pulses;
      repeat (resume_words) write_word(sample_feed_pkg::word_t'($urandom));
      finish_phase(starve_mark, "resume");

      // Write every cycle until full
      starve_mark = starve_pulses;
      written     = 0;
      while (!fifo_full && written < full_words) begin
         write_word(sample_feed_pkg::word_t'($urandom));
         written++;
      end
      if (!fifo_full) begin
         log_failure("fifo_full never rose");
      end
      assert (fifo_level == sample_feed_pkg::level_t'(words_accepted - words_popped))
      else report_mismatch("fifo_level", words_accepted - words_popped, int'(fifo_level));
      finish_phase(starve_mark, "full");

      // Single word into an idle design
      apply_reset();
      starve_mark = starve_pulses;
      latency_arm = 1'b1;
      write_word(sample_feed_pkg::word_t'($urandom));
      latency_arm = 1'b0;
      finish_phase(starve_mark, "latency");

      $display("Done: %0d samples checked, %0d errors", samples_checked, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
rtl/sample_feed_pkg.sv
rtl/word_fifo.sv
rtl/bit_residue_counter.sv
rtl/feed_control.sv
rtl/sample_unpacker.sv
rtl/sample_feed.sv
test/sample_feed_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module sample_feed_tb -o sample_feed_sim -f src.f

./obj_dir/sample_feed_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
   exit 1
fi
if ! grep -q "sim passed" sim.log; then
   echo "No result found in sim.log"
   exit 1
fi
